// ==== hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

    typedef logic [4:0] reg_addr_t;

    // major opcodes the decoder understands
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // longest stall any hazard can ask for
    localparam int MAX_STALL = 2;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]  imm_hi;
        reg_addr_t   rs2;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t i_view;
        s_fmt_t s_view;
    } inst_word_u;

    typedef struct packed {
        logic        valid;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        logic        use_rs1;
        reg_addr_t   rs2;
        logic        use_rs2;
        logic        is_load;
        logic        is_store;
        logic [11:0] offset;
        logic        writes_rd;   // low for x0 so a dependency on x0 can never match
    } uop_t;

    typedef enum logic [1:0] {
        HZ_NONE,
        HZ_LOAD_EX,
        HZ_LOAD_MEM,
        HZ_STORE_ALIAS
    } hazard_kind_e;

    typedef struct packed {
        hazard_kind_e kind;
        logic [1:0]   len;        // stall cycles, 0 to MAX_STALL
    } hazard_t;

endpackage

`default_nettype wire

// ==== inst_decode.sv ====
`default_nettype none
`timescale 1ns/10ps

module inst_decode (
    input  hazard_pkg::inst_word_u inst,
    input  logic                   valid,
    output hazard_pkg::uop_t       uop
);

    logic [6:0] opcode;
    logic       writes;

    assign opcode = inst.i_view.opcode;

    always_comb begin
        uop         = '0;
        writes      = 1'b0;
        uop.valid   = valid;
        uop.rd      = inst.i_view.rd;
        uop.rs1     = inst.i_view.rs1;
        uop.rs2     = inst.s_view.rs2;   // same bits for R-type and branches
        uop.offset  = inst.i_view.imm;

        case (opcode)
            hazard_pkg::OPC_LOAD: begin
                uop.use_rs1 = 1'b1;
                uop.is_load = 1'b1;
                writes      = 1'b1;
            end
            hazard_pkg::OPC_STORE: begin
                uop.use_rs1  = 1'b1;
                uop.use_rs2  = 1'b1;
                uop.is_store = 1'b1;
                uop.offset   = {inst.s_view.imm_hi, inst.s_view.imm_lo};   // split immediate
            end
            hazard_pkg::OPC_OP: begin
                uop.use_rs1 = 1'b1;
                uop.use_rs2 = 1'b1;
                writes      = 1'b1;
            end
            hazard_pkg::OPC_OP_IMM: begin
                uop.use_rs1 = 1'b1;
                writes      = 1'b1;
            end
            hazard_pkg::OPC_LUI: begin
                writes = 1'b1;
            end
            hazard_pkg::OPC_BRANCH: begin
                uop.use_rs1 = 1'b1;
                uop.use_rs2 = 1'b1;
            end
            default: begin
                writes = 1'b0;   // unknown opcodes touch no register
            end
        endcase

        uop.writes_rd = writes && (inst.i_view.rd != '0);
    end

endmodule

`default_nettype wire

// ==== stage_tracker.sv ====
`default_nettype none
`timescale 1ns/10ps

module stage_tracker (
    input  logic             clk,
    input  logic             rst_n,
    input  hazard_pkg::uop_t id_uop,
    input  logic             stall,
    input  logic             flush,
    output hazard_pkg::uop_t ex_uop,
    output hazard_pkg::uop_t mem_uop,
    output hazard_pkg::uop_t wb_uop
);

    logic             ex_valid_q;
    logic             mem_valid_q;
    logic             wb_valid_q;
    hazard_pkg::uop_t ex_q;
    hazard_pkg::uop_t mem_q;
    hazard_pkg::uop_t wb_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid_q  <= 1'b0;
            mem_valid_q <= 1'b0;
            wb_valid_q  <= 1'b0;
        end else begin
            ex_valid_q  <= id_uop.valid && !stall && !flush;   // bubble on hold or kill
            mem_valid_q <= ex_valid_q;
            wb_valid_q  <= mem_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        ex_q  <= id_uop;
        mem_q <= ex_q;
        wb_q  <= mem_q;
    end

    always_comb begin
        ex_uop        = ex_q;
        ex_uop.valid  = ex_valid_q;
        mem_uop       = mem_q;
        mem_uop.valid = mem_valid_q;
        wb_uop        = wb_q;
        wb_uop.valid  = wb_valid_q;
    end

    // a held decode slot must stay unchanged until it can enter execute
    held_uop_stable_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> $stable(id_uop)
    );

endmodule

`default_nettype wire

// ==== hazard_detect.sv ====
`default_nettype none
`timescale 1ns/10ps

module hazard_detect (
    input  hazard_pkg::uop_t    id_uop,
    input  hazard_pkg::uop_t    ex_uop,
    input  hazard_pkg::uop_t    mem_uop,
    output hazard_pkg::hazard_t hit
);

    logic load_ex;
    logic load_mem;
    logic store_alias;

    // true when consumer reads a register that a load in the given slot will write
    function automatic logic reads_load_dest(
        input hazard_pkg::uop_t cons,
        input hazard_pkg::uop_t prod
    );
        logic src1_hit;
        logic src2_hit;
        src1_hit = cons.use_rs1 && (cons.rs1 == prod.rd);
        src2_hit = cons.use_rs2 && (cons.rs2 == prod.rd);
        return prod.valid && prod.is_load && prod.writes_rd && (src1_hit || src2_hit);
    endfunction

    assign load_ex  = reads_load_dest(id_uop, ex_uop);
    assign load_mem = reads_load_dest(id_uop, mem_uop);

    // conservative alias check, no real address is available here
    assign store_alias = id_uop.is_load && ex_uop.valid && ex_uop.is_store &&
                         (id_uop.rs1 == ex_uop.rs1) && (id_uop.offset == ex_uop.offset);

    always_comb begin
        hit.kind = hazard_pkg::HZ_NONE;
        hit.len  = 2'd0;
        if (id_uop.valid) begin
            if (load_ex) begin
                hit.kind = hazard_pkg::HZ_LOAD_EX;
                hit.len  = 2'(hazard_pkg::MAX_STALL);
            end else if (load_mem) begin
                hit.kind = hazard_pkg::HZ_LOAD_MEM;
                hit.len  = 2'(hazard_pkg::MAX_STALL - 1);
            end else if (store_alias) begin
                hit.kind = hazard_pkg::HZ_STORE_ALIAS;
                hit.len  = 2'd1;   // store leaves execute after one cycle
            end
        end
    end

endmodule

`default_nettype wire

// ==== stall_fsm.sv ====
`default_nettype none
`timescale 1ns/10ps

module stall_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    input  hazard_pkg::hazard_t      hit,
    input  logic                     flush,
    input  logic                     expired,
    output logic                     stall,
    output hazard_pkg::hazard_kind_e stall_kind,
    output logic                     timer_load,
    output logic [1:0]               load_len
);

    typedef enum logic {
        IDLE,
        HOLD
    } state_e;

    state_e                   state_q;
    state_e                   state_d;
    hazard_pkg::hazard_kind_e kind_q;
    logic                     hit_any;

    assign hit_any  = (hit.kind != hazard_pkg::HZ_NONE);
    assign load_len = hit.len;

    always_comb begin
        state_d    = state_q;
        stall      = 1'b0;
        stall_kind = hazard_pkg::HZ_NONE;
        timer_load = 1'b0;
        if (flush) begin
            state_d = IDLE;   // flush wins over any pending hold
        end else if (state_q == IDLE) begin
            stall      = hit_any;
            stall_kind = hit.kind;
            if (hit_any && (hit.len > 2'd1)) begin
                timer_load = 1'b1;
                state_d    = HOLD;
            end
        end else begin
            stall      = !expired;   // detection stays masked here
            stall_kind = expired ? hazard_pkg::HZ_NONE : kind_q;
            if (expired) begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            kind_q  <= hazard_pkg::HZ_NONE;
        end else begin
            state_q <= state_d;
            if (timer_load) begin
                kind_q <= hit.kind;
            end
        end
    end

    // with no hold running the countdown must already be spent
    timer_spent_in_idle_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == IDLE) |-> expired
    );

endmodule

`default_nettype wire

// ==== stall_timer.sv ====
`default_nettype none
`timescale 1ns/10ps

module stall_timer #(
    parameter int STALL_CNT_W = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   timer_load,
    input  logic [1:0]             load_len,
    input  logic                   flush,
    input  logic                   stall,
    output logic                   expired,
    output logic [STALL_CNT_W-1:0] stall_cycles
);

    localparam int CD_W = $clog2(hazard_pkg::MAX_STALL);

    logic [CD_W-1:0] count_q;

    // the first stall cycle is spent before the load, hence len minus 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (flush) begin
            count_q <= '0;
        end else if (timer_load) begin
            count_q <= CD_W'(load_len - 2'd1);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign expired = (count_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_cycles <= '0;
        end else if (stall && (stall_cycles != '1)) begin
            stall_cycles <= stall_cycles + 1'b1;   // holds at all ones
        end
    end

    // a new hold may only start once the previous one has run out
    load_when_idle_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        timer_load |-> (count_q == '0)
    );

endmodule

`default_nettype wire

// ==== hazard_ctrl_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module hazard_ctrl_top #(
    parameter int STALL_CNT_W = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     id_valid,
    input  logic [31:0]              id_inst,
    input  logic                     flush,
    output logic                     stall,
    output hazard_pkg::hazard_kind_e stall_kind,
    output logic                     wb_valid,
    output hazard_pkg::reg_addr_t    wb_rd,
    output logic [STALL_CNT_W-1:0]   stall_cycles
);

    hazard_pkg::uop_t    id_uop;
    hazard_pkg::uop_t    ex_uop;
    hazard_pkg::uop_t    mem_uop;
    hazard_pkg::uop_t    wb_uop;
    hazard_pkg::hazard_t hit;
    logic                timer_load;
    logic [1:0]          load_len;
    logic                expired;

    inst_decode u_inst_decode (
        .inst  (hazard_pkg::inst_word_u'(id_inst)),
        .valid (id_valid),
        .uop   (id_uop)
    );

    stage_tracker u_stage_tracker (
        .clk     (clk),
        .rst_n   (rst_n),
        .id_uop  (id_uop),
        .stall   (stall),
        .flush   (flush),
        .ex_uop  (ex_uop),
        .mem_uop (mem_uop),
        .wb_uop  (wb_uop)
    );

    hazard_detect u_hazard_detect (
        .id_uop  (id_uop),
        .ex_uop  (ex_uop),
        .mem_uop (mem_uop),
        .hit     (hit)
    );

    stall_fsm u_stall_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .hit        (hit),
        .flush      (flush),
        .expired    (expired),
        .stall      (stall),
        .stall_kind (stall_kind),
        .timer_load (timer_load),
        .load_len   (load_len)
    );

    stall_timer #(
        .STALL_CNT_W (STALL_CNT_W)
    ) u_stall_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .timer_load   (timer_load),
        .load_len     (load_len),
        .flush        (flush),
        .stall        (stall),
        .expired      (expired),
        .stall_cycles (stall_cycles)
    );

    assign wb_valid = wb_uop.valid;
    assign wb_rd    = wb_uop.rd;

endmodule

`default_nettype wire

// ==== tb_hazard_ctrl.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_hazard_ctrl;

    localparam int STALL_CNT_W = 16;
    localparam int STALL_LIMIT = 8;
    localparam int DRAIN_LIMIT = 10;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     id_valid;
    logic [31:0]              id_inst;
    logic                     flush;
    logic                     stall;
    hazard_pkg::hazard_kind_e stall_kind;
    logic                     wb_valid;
    hazard_pkg::reg_addr_t    wb_rd;
    logic [STALL_CNT_W-1:0]   stall_cycles;

    int errors = 0;
    int checks = 0;
    int cyc = 0;
    int exp_stall_total = 0;
    logic mon_en = 1'b0;

    // expected writeback, one entry per issued instruction
    int                    exp_cyc[$];
    hazard_pkg::reg_addr_t exp_rd[$];
    logic                  exp_chk[$];

    hazard_ctrl_top #(
        .STALL_CNT_W (STALL_CNT_W)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .id_valid     (id_valid),
        .id_inst      (id_inst),
        .flush        (flush),
        .stall        (stall),
        .stall_kind   (stall_kind),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .stall_cycles (stall_cycles)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_kind(input string name, input hazard_pkg::hazard_kind_e exp,
                              input hazard_pkg::hazard_kind_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_rd(input string name, input hazard_pkg::reg_addr_t exp,
                            input hazard_pkg::reg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected x%0d got x%0d", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [STALL_CNT_W-1:0] exp,
                               input logic [STALL_CNT_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // writeback must match the queue head in its cycle and be empty otherwise
    always @(negedge clk) begin
        if (mon_en) begin
            if (exp_cyc.size() != 0 && exp_cyc[0] == cyc) begin
                check_bit("wb_valid", 1'b1, wb_valid);
                if (exp_chk[0]) begin
                    check_rd("wb_rd", exp_rd[0], wb_rd);
                end
                void'(exp_cyc.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_chk.pop_front());
            end else begin
                check_bit("wb_valid", 1'b0, wb_valid);
            end
        end
    end

    function automatic logic [31:0] load_inst(input hazard_pkg::reg_addr_t rd,
                                              input hazard_pkg::reg_addr_t base,
                                              input logic [11:0] off);
        return {off, base, 3'b011, rd, hazard_pkg::OPC_LOAD};
    endfunction

    function automatic logic [31:0] store_inst(input hazard_pkg::reg_addr_t data,
                                               input hazard_pkg::reg_addr_t base,
                                               input logic [11:0] off);
        return {off[11:5], data, base, 3'b011, off[4:0], hazard_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] add_inst(input hazard_pkg::reg_addr_t rd,
                                             input hazard_pkg::reg_addr_t rs1,
                                             input hazard_pkg::reg_addr_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, hazard_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] addi_inst(input hazard_pkg::reg_addr_t rd,
                                              input hazard_pkg::reg_addr_t rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, hazard_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_inst(input hazard_pkg::reg_addr_t rd,
                                             input logic [19:0] imm);
        return {imm, rd, hazard_pkg::OPC_LUI};
    endfunction

    function automatic hazard_pkg::reg_addr_t pick_reg();
        return hazard_pkg::reg_addr_t'(1 + ($urandom % 31));   // never x0
    endfunction

    // present one instruction, measure its stall, then expect it in writeback 3 cycles on
    task automatic issue(input logic [31:0] inst, input logic has_rd, input int exp_len,
                         input hazard_pkg::hazard_kind_e exp_kind);
        int held;
        held = 0;
        @(posedge clk);
        id_inst  <= inst;
        id_valid <= 1'b1;
        @(negedge clk);
        while (stall && held < STALL_LIMIT) begin
            check_kind("stall_kind", exp_kind, stall_kind);
            held++;
            @(negedge clk);
        end
        if (stall) begin
            errors++;
            $display("stall stayed high for more than %0d cycles at t=%0t", STALL_LIMIT, $time);
        end
        check_count("stall length", STALL_CNT_W'(exp_len), STALL_CNT_W'(held));
        check_kind("stall_kind", hazard_pkg::HZ_NONE, stall_kind);
        exp_stall_total += exp_len;
        exp_cyc.push_back(cyc + 3);
        exp_rd.push_back(inst[11:7]);
        exp_chk.push_back(has_rd);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            id_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_cyc.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_cyc.size() != 0) begin
            errors++;
            $display("%0d instructions never reached writeback", exp_cyc.size());
        end
    endtask

    task automatic alu_stream();
        hazard_pkg::reg_addr_t rd;
        hazard_pkg::reg_addr_t rs1;
        hazard_pkg::reg_addr_t rs2;
        for (int i = 0; i < 8; i++) begin
            rd  = pick_reg();
            rs1 = pick_reg();
            rs2 = pick_reg();
            if (i % 2 == 0) begin
                issue(add_inst(rd, rs1, rs2), 1'b1, 0, hazard_pkg::HZ_NONE);
            end else begin
                issue(addi_inst(rd, rs1, 12'(i)), 1'b1, 0, hazard_pkg::HZ_NONE);
            end
        end
        idle(3);
    endtask

    task automatic load_use();
        hazard_pkg::reg_addr_t ld_rd;
        ld_rd = pick_reg();
        issue(load_inst(ld_rd, 5'd2, 12'h010), 1'b1, 0, hazard_pkg::HZ_NONE);
        issue(add_inst(5'd6, ld_rd, 5'd7), 1'b1, 2, hazard_pkg::HZ_LOAD_EX);
        idle(3);
        // store data comes through rs2
        issue(load_inst(5'd21, 5'd2, 12'h018), 1'b1, 0, hazard_pkg::HZ_NONE);
        issue(store_inst(5'd21, 5'd3, 12'h020), 1'b0, 2, hazard_pkg::HZ_LOAD_EX);
        idle(3);
    endtask

    task automatic load_mem_use();
        issue(load_inst(5'd8, 5'd2, 12'h000), 1'b1, 0, hazard_pkg::HZ_NONE);
        issue(addi_inst(5'd9, 5'd1, 12'd5), 1'b1, 0, hazard_pkg::HZ_NONE);
        issue(add_inst(5'd10, 5'd8, 5'd0), 1'b1, 1, hazard_pkg::HZ_LOAD_MEM);
        idle(3);
    endtask

    task automatic store_load_alias();
        issue(store_inst(5'd5, 5'd4, 12'h123), 1'b0, 0, hazard_pkg::HZ_NONE);
        issue(load_inst(5'd11, 5'd4, 12'h123), 1'b1, 1, hazard_pkg::HZ_STORE_ALIAS);
        idle(3);
        issue(store_inst(5'd5, 5'd4, 12'h123), 1'b0, 0, hazard_pkg::HZ_NONE);
        issue(load_inst(5'd12, 5'd4, 12'h103), 1'b1, 0, hazard_pkg::HZ_NONE);   // offset differs in imm_hi
        idle(3);
    endtask

    task automatic zero_reg_cases();
        issue(load_inst(5'd0, 5'd2, 12'h008), 1'b1, 0, hazard_pkg::HZ_NONE);
        issue(add_inst(5'd13, 5'd0, 5'd0), 1'b1, 0, hazard_pkg::HZ_NONE);
        idle(3);
        issue(load_inst(5'd16, 5'd2, 12'h000), 1'b1, 0, hazard_pkg::HZ_NONE);
        issue(lui_inst(5'd16, 20'h12345), 1'b1, 0, hazard_pkg::HZ_NONE);
        idle(3);
    endtask

    task automatic flush_during_hold();
        hazard_pkg::reg_addr_t ld_rd;
        ld_rd = pick_reg();
        issue(load_inst(ld_rd, 5'd2, 12'h000), 1'b1, 0, hazard_pkg::HZ_NONE);
        @(posedge clk);
        id_inst  <= add_inst(5'd18, ld_rd, 5'd1);
        id_valid <= 1'b1;
        @(negedge clk);
        check_bit("stall", 1'b1, stall);
        check_kind("stall_kind", hazard_pkg::HZ_LOAD_EX, stall_kind);
        @(posedge clk);
        flush <= 1'b1;   // second cycle of the hold
        @(negedge clk);
        check_bit("stall", 1'b0, stall);
        check_kind("stall_kind", hazard_pkg::HZ_NONE, stall_kind);
        exp_stall_total += 1;
        @(posedge clk);
        flush    <= 1'b0;
        id_valid <= 1'b0;
        idle(3);
    endtask

    initial begin
        void'($urandom(55));
        rst_n    = 1'b0;
        id_valid = 1'b0;
        id_inst  = '0;
        flush    = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("stall", 1'b0, stall);
        check_bit("wb_valid", 1'b0, wb_valid);
        check_kind("stall_kind", hazard_pkg::HZ_NONE, stall_kind);
        check_count("stall_cycles", '0, stall_cycles);
        mon_en <= 1'b1;

        alu_stream();
        load_use();
        load_mem_use();
        store_load_alias();
        zero_reg_cases();
        flush_during_hold();
        drain();

        @(negedge clk);
        check_count("stall_cycles", STALL_CNT_W'(exp_stall_total), stall_cycles);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hazard_pkg.sv
inst_decode.sv
stage_tracker.sv
hazard_detect.sv
stall_fsm.sv
stall_timer.sv
hazard_ctrl_top.sv
tb_hazard_ctrl.sv

// ==== Bender.yml ====
package:
  name: hazard_ctrl

sources:
  - hazard_pkg.sv
  - inst_decode.sv
  - stage_tracker.sv
  - hazard_detect.sv
  - stall_fsm.sv
  - stall_timer.sv
  - hazard_ctrl_top.sv
  - target: test
    files:
      - tb_hazard_ctrl.sv
